// ==== lcd_bus_pkg.sv ====
package lcd_bus_pkg;

	// opcode class patterns, the highest set bit picks the instruction
	typedef enum logic [7:0] {
		lcd_op_clear = 8'b0000_0001,
		lcd_op_entry = 8'b0000_0100,
		lcd_op_display = 8'b0000_1000,
		lcd_op_func = 8'b0010_0000
	} lcd_op_e;

	// DL bit of function set, eight-bit interface
	localparam logic [7:0] lcd_fs_dl8 = 8'b0001_0000;

	// panel word seen as an instruction, rs low
	typedef struct packed {
		logic rs;
		logic rw;
		logic [7:0] opcode; // class bits plus its fields
	} lcd_instr_t;

	// panel word seen as a character write, rs high
	typedef struct packed {
		logic rs;
		logic rw;
		logic [7:0] code; // CGROM character code
	} lcd_char_t;

	// one ten-bit word on the panel bus
	typedef union packed {
		lcd_instr_t instr;
		lcd_char_t chr;
	} lcd_word_u;

endpackage

// ==== lcd_bus_timer.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_bus_timer import lcd_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input lcd_word_u word,
	input logic [`LCD_SLOT_W-1:0] slot_us,
	output logic idle,
	output logic done,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data
);

	localparam logic [`LCD_CYC_W-1:0] setup_cyc = `LCD_CYC_W'(`LCD_US2CYC(`LCD_SETUP_US));
	localparam logic [`LCD_CYC_W-1:0] high_cyc = `LCD_CYC_W'(`LCD_US2CYC(`LCD_E_HIGH_US));
	localparam logic [`LCD_CYC_W-1:0] e_off = setup_cyc + high_cyc;

	logic busy;
	logic [`LCD_CYC_W-1:0] cnt; // cycles since start was taken
	logic [`LCD_CYC_W-1:0] slot_cyc;

	assign idle = !busy;

	// cnt is 1 in the first cycle after start, the slot ends when it reaches slot_cyc
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			lcd_e <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_rw <= 1'b0;
			lcd_data <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					cnt <= `LCD_CYC_W'(1);
					lcd_rs <= word.instr.rs; // bus valid from here
					lcd_rw <= word.instr.rw;
					lcd_data <= word.instr.opcode;
				end
			end else begin
				cnt <= cnt + 1'b1;
				lcd_e <= (cnt >= setup_cyc) && (cnt < e_off); // high for cnt setup+1..e_off
				if (cnt == e_off) begin
					// enable falls now, bus back to idle zero
					lcd_rs <= 1'b0;
					lcd_rw <= 1'b0;
					lcd_data <= '0;
				end
				if (cnt + 1'b1 == slot_cyc) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && start)
			slot_cyc <= `LCD_CYC_W'(`LCD_US2CYC(slot_us));
	end

endmodule

// ==== lcd_cfg_pkg.sv ====
package lcd_cfg_pkg;

	// static panel setup, sampled when the init sequence runs
	typedef struct packed {
		logic two_lines; // N bit of function set
		logic font_5x10; // F bit of function set
		logic display_on; // D bit of display control
		logic cursor_on; // C bit
		logic blink_on; // B bit
		logic increment; // I/D bit of entry mode
		logic shift; // S bit, shift display on write
	} lcd_cfg_t;

endpackage

// ==== lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// clock cycles per microsecond, raise to the real clock rate on hardware
`define LCD_CLK_PER_US 4

// converts a delay in microseconds into clock cycles
`define LCD_US2CYC(us) ((us) * `LCD_CLK_PER_US)

`define LCD_POWERUP_US 500 // panel power-up wait
`define LCD_SETUP_US 1 // bus valid to enable rising
`define LCD_E_HIGH_US 13 // enable high time
`define LCD_CMD_SLOT_US 50 // full slot of a host write

// init slots, enable phase plus the settle time of each step
`define LCD_INIT_SLOT0_US 60 // function set
`define LCD_INIT_SLOT1_US 60 // display on/off control
`define LCD_INIT_SLOT2_US 210 // display clear
`define LCD_INIT_SLOT3_US 110 // entry mode set

`define LCD_QUEUE_DEPTH 4 // host request FIFO entries

`define LCD_SLOT_W 9 // slot length in us
`define LCD_CYC_W 20 // cycle counters, room for 500 us at 50 MHz

`endif

// ==== lcd_ctrl.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_ctrl import lcd_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	output logic [1:0] step_idx,
	input lcd_word_u init_word,
	input logic [`LCD_SLOT_W-1:0] init_slot,
	input logic q_valid,
	output logic q_ready,
	input lcd_word_u q_word,
	output logic start,
	output lcd_word_u word,
	output logic [`LCD_SLOT_W-1:0] slot_us,
	input logic idle,
	input logic done,
	output logic init_done
);

	localparam logic [`LCD_CYC_W-1:0] pwr_last =
		`LCD_CYC_W'(`LCD_US2CYC(`LCD_POWERUP_US) - 1);

	typedef enum logic [2:0] {
		power_wait,
		init_issue,
		init_wait,
		run_idle,
		run_wait
	} state_t;

	state_t state;
	logic [1:0] step; // next init step to send
	logic [`LCD_CYC_W-1:0] pwr_cnt;
	logic issue_init;
	logic issue_host;

	assign step_idx = step;

	// pop only when the timer is free and no start is in flight
	assign q_ready = (state == run_idle || state == run_wait) && idle && !start;
	assign issue_host = q_valid && q_ready;

	// step wraps to 0 once step 3 has gone out
	assign issue_init = (state == init_issue && idle) ||
		(state == init_wait && done && step != 2'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= power_wait;
			step <= 2'd0;
			pwr_cnt <= '0;
			start <= 1'b0;
			init_done <= 1'b0;
		end else begin
			start <= issue_init || issue_host;
			if (issue_init)
				step <= step + 1'b1;
			case (state)
				power_wait: begin
					pwr_cnt <= pwr_cnt + 1'b1;
					if (pwr_cnt == pwr_last)
						state <= init_issue;
				end
				init_issue: if (idle) state <= init_wait;
				init_wait: begin
					if (done && step == 2'd0) begin
						init_done <= 1'b1; // fourth slot over
						state <= run_idle;
					end
				end
				run_idle: if (issue_host) state <= run_wait;
				run_wait: begin
					if (!issue_host && idle && !start)
						state <= run_idle; // slot over, queue empty
				end
				default: state <= power_wait;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue_init) begin
			word <= init_word;
			slot_us <= init_slot;
		end else if (issue_host) begin
			word <= q_word;
			slot_us <= `LCD_SLOT_W'(`LCD_CMD_SLOT_US);
		end
	end

endmodule

// ==== lcd_init_seq.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_init_seq import lcd_cfg_pkg::*, lcd_bus_pkg::*; (
	input logic [1:0] step_idx,
	input lcd_cfg_t cfg,
	output lcd_word_u init_word,
	output logic [`LCD_SLOT_W-1:0] init_slot
);

	logic [7:0] opcode;

	// instruction byte of each init step
	always_comb begin
		case (step_idx)
			2'd0: begin
				// 8-bit bus, line count and font
				opcode = lcd_op_func | lcd_fs_dl8 |
					{4'b0000, cfg.two_lines, cfg.font_5x10, 2'b00};
				init_slot = `LCD_SLOT_W'(`LCD_INIT_SLOT0_US);
			end
			2'd1: begin
				opcode = lcd_op_display |
					{5'b00000, cfg.display_on, cfg.cursor_on, cfg.blink_on};
				init_slot = `LCD_SLOT_W'(`LCD_INIT_SLOT1_US);
			end
			2'd2: begin
				opcode = lcd_op_clear; // long slot, panel clears its RAM
				init_slot = `LCD_SLOT_W'(`LCD_INIT_SLOT2_US);
			end
			default: begin
				opcode = lcd_op_entry | {6'b000000, cfg.increment, cfg.shift};
				init_slot = `LCD_SLOT_W'(`LCD_INIT_SLOT3_US);
			end
		endcase
	end

	always_comb begin
		init_word.instr.rs = 1'b0; // all init steps are instructions
		init_word.instr.rw = 1'b0;
		init_word.instr.opcode = opcode;
	end

endmodule

// ==== lcd_req_queue.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_req_queue import lcd_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic req_valid,
	output logic req_ready,
	input logic req_rs,
	input logic [7:0] req_data,
	output logic q_valid,
	input logic q_ready,
	output lcd_word_u q_word
);

	localparam int depth = `LCD_QUEUE_DEPTH;
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	lcd_word_u mem [depth];
	lcd_word_u in_word;
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_nxt;
	logic push;
	logic pop;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(depth - 1)) ? '0 : p + 1'b1; // wrap for any depth
	endfunction

	assign req_ready = (count != cnt_w'(depth)); // room left, valid not looked at
	assign push = req_valid && req_ready;
	assign pop = q_valid && q_ready;
	assign q_word = mem[rd_ptr];

	always_comb begin
		in_word.chr.rs = req_rs;
		in_word.chr.rw = 1'b0; // write-only panel
		in_word.chr.code = req_data;
	end

	always_comb begin
		case ({push, pop})
			2'b10: count_nxt = count + 1'b1;
			2'b01: count_nxt = count - 1'b1;
			default: count_nxt = count; // none, or push and pop together
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			q_valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count_nxt;
			q_valid <= (count_nxt != '0); // registered, one cycle after push
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_word;
	end

endmodule

// ==== lcd_tb.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_tb import lcd_cfg_pkg::*, lcd_bus_pkg::*;;

	localparam int setup_cyc = `LCD_US2CYC(`LCD_SETUP_US);
	localparam int high_cyc = `LCD_US2CYC(`LCD_E_HIGH_US);
	localparam int pwr_cyc = `LCD_US2CYC(`LCD_POWERUP_US);
	localparam int cmd_cyc = `LCD_US2CYC(`LCD_CMD_SLOT_US);
	localparam int n_single = 8; // one-at-a-time host writes
	localparam int n_burst = `LCD_QUEUE_DEPTH + 3; // enough to fill the FIFO
	localparam int init_us = `LCD_INIT_SLOT0_US + `LCD_INIT_SLOT1_US +
		`LCD_INIT_SLOT2_US + `LCD_INIT_SLOT3_US;
	localparam int run_us = `LCD_POWERUP_US + init_us + (n_single + n_burst) * `LCD_CMD_SLOT_US;
	localparam int watchdog_cyc = `LCD_US2CYC(run_us) * 3 / 2;

	logic clk;
	logic rst_n;
	lcd_cfg_t cfg;
	logic req_valid;
	logic req_ready;
	logic req_rs;
	logic [7:0] req_data;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;
	logic init_done;
	logic [9:0] bus_now;

	int errors = 0;
	int cyc = 0;
	int rst_cyc;
	int done_cyc = 0;
	int words_at_done = -1;
	int bus_chg_cyc = 0;
	int init_slot_us [4] = '{`LCD_INIT_SLOT0_US, `LCD_INIT_SLOT1_US,
		`LCD_INIT_SLOT2_US, `LCD_INIT_SLOT3_US};
	logic [9:0] exp_q [$];
	logic [9:0] obs_q [$];
	int rise_q [$];
	int high_q [$];
	logic e_prev = 1'b0;
	logic done_prev = 1'b0;
	logic [9:0] bus_prev = '0;
	logic [9:0] cur_word = '0;

	assign bus_now = {lcd_rs, lcd_rw, lcd_data};

	lcd_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.cfg(cfg),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_rs(req_rs),
		.req_data(req_data),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_data(lcd_data),
		.init_done(init_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) cyc = cyc + 1;

	task automatic note_mismatch(input string name, input int got, input int exp);
		$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		errors++;
	endtask

	task automatic note_fault(input string what);
		$display("error: %s", what);
		errors++;
	endtask

	// panel-side monitor sampled between rising edges
	always @(negedge clk) begin
		if (lcd_rw !== 1'b0) note_mismatch("lcd_rw", int'(lcd_rw), 0);
		if (bus_now != bus_prev) bus_chg_cyc = cyc;
		if (lcd_e && !e_prev) begin
			rise_q.push_back(cyc);
			cur_word = bus_now;
			if (cyc - bus_chg_cyc < setup_cyc) note_fault("bus changed too close to enable rise");
		end else if (lcd_e && bus_now != cur_word) begin
			note_fault("panel bus changed while enable was high");
		end
		if (!lcd_e && e_prev) begin
			obs_q.push_back(cur_word); // word latched by the panel here
			high_q.push_back(cyc - rise_q[$]);
		end
		if (init_done && !done_prev) begin
			done_cyc = cyc;
			words_at_done = obs_q.size();
		end
		e_prev = lcd_e;
		done_prev = init_done;
		bus_prev = bus_now;
	end

	task automatic wait_words(input int n, input int limit);
		int waited;
		waited = 0;
		while (obs_q.size() < n && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (obs_q.size() < n) note_fault($sformatf("only %0d of %0d words reached the panel",
			obs_q.size(), n));
	endtask

	task automatic compare_words(input int first);
		for (int i = first; i < exp_q.size(); i++) begin
			if (i >= obs_q.size()) begin
				note_fault($sformatf("panel word %0d never appeared", i));
				break;
			end
			if (obs_q[i] !== exp_q[i]) note_mismatch($sformatf("panel word %0d {rs,rw,data}", i),
				int'(obs_q[i]), int'(exp_q[i]));
		end
	endtask

	// called on a falling edge and leaves valid high for a following word
	task automatic push_word(input logic rs, input logic [7:0] data, output int stalls);
		req_valid = 1'b1;
		req_rs = rs;
		req_data = data;
		stalls = 0;
		while (!req_ready && stalls < 4 * cmd_cyc) begin
			@(negedge clk);
			stalls++;
		end
		if (!req_ready) note_fault("req_ready stayed low, host word not accepted");
		@(negedge clk);
	endtask

	task automatic test_init_words();
		logic [7:0] fs;
		logic [7:0] dc;
		logic [7:0] em;
		int waited;
		if (init_done !== 1'b0) note_mismatch("init_done", int'(init_done), 0);
		if (req_ready !== 1'b1) note_mismatch("req_ready", int'(req_ready), 1);
		fs = lcd_op_func;
		fs[4] = 1'b1; // DL set for the 8-bit bus
		fs[3] = cfg.two_lines; // N
		fs[2] = cfg.font_5x10; // F
		dc = lcd_op_display;
		dc[2] = cfg.display_on; // D
		dc[1] = cfg.cursor_on; // C
		dc[0] = cfg.blink_on; // B
		em = lcd_op_entry;
		em[1] = cfg.increment; // I/D
		em[0] = cfg.shift; // S
		exp_q.push_back({2'b00, fs});
		exp_q.push_back({2'b00, dc});
		exp_q.push_back({2'b00, 8'(lcd_op_clear)});
		exp_q.push_back({2'b00, em});
		waited = 0;
		while (!init_done && waited < 2 * `LCD_US2CYC(`LCD_POWERUP_US + init_us)) begin
			@(negedge clk);
			waited++;
		end
		@(negedge clk);
		if (!init_done) note_fault("init_done never rose");
		if (words_at_done != 4) note_mismatch("words before init_done", words_at_done, 4);
		compare_words(0);
		// init_done follows the end of the last slot
		if (rise_q.size() >= 4 && (done_cyc - rise_q[3] < `LCD_US2CYC(`LCD_INIT_SLOT3_US) -
			setup_cyc || done_cyc - rise_q[3] > `LCD_US2CYC(`LCD_INIT_SLOT3_US) - setup_cyc + 2))
			note_mismatch("init_done delay after last enable", done_cyc - rise_q[3],
				`LCD_US2CYC(`LCD_INIT_SLOT3_US) - setup_cyc);
	endtask

	task automatic test_host_writes();
		logic rs;
		logic [7:0] data;
		int stalls;
		for (int i = 0; i < n_single; i++) begin
			rs = i[0]; // odd words are characters
			data = rs ? 8'($urandom) : 8'h80 | 8'(i); // set DDRAM address
			@(negedge clk);
			push_word(rs, data, stalls);
			req_valid = 1'b0;
			if (stalls != 0) note_fault("req_ready was low while the FIFO had room");
			exp_q.push_back({rs, 1'b0, data});
			wait_words(exp_q.size(), 2 * cmd_cyc);
		end
		compare_words(4);
	endtask

	task automatic test_back_pressure();
		logic [7:0] data;
		int first;
		int stalls;
		int total;
		first = exp_q.size();
		total = 0;
		@(negedge clk);
		for (int i = 0; i < n_burst; i++) begin
			data = 8'($urandom);
			push_word(1'b1, data, stalls);
			exp_q.push_back({2'b10, data});
			total += stalls;
		end
		req_valid = 1'b0;
		if (total == 0) note_fault("req_ready never dropped while the FIFO was full");
		wait_words(exp_q.size(), 2 * n_burst * cmd_cyc);
		compare_words(first);
		if (obs_q.size() != exp_q.size()) note_mismatch("panel word count", obs_q.size(),
			exp_q.size());
	endtask

	task automatic test_pulse_timing();
		int first;
		if (rise_q.size() == 0) begin
			note_fault("no enable pulse seen");
			return;
		end
		first = rise_q[0] - rst_cyc;
		if (first < pwr_cyc) note_fault("enable rose before the power-up wait ended");
		if (first < pwr_cyc + setup_cyc - 2 || first > pwr_cyc + setup_cyc + 2)
			note_mismatch("first enable rise cycle", first, pwr_cyc + setup_cyc);
		foreach (high_q[i])
			if (high_q[i] != high_cyc) note_mismatch($sformatf("lcd_e high time %0d", i),
				high_q[i], high_cyc);
	endtask

	task automatic test_slot_spacing();
		int need;
		for (int i = 1; i < rise_q.size(); i++) begin
			need = (i <= 4) ? `LCD_US2CYC(init_slot_us[i-1]) : cmd_cyc;
			if (rise_q[i] - rise_q[i-1] < need) note_fault($sformatf(
				"enable %0d rose %0d cycles after the previous one, slot is %0d",
				i, rise_q[i] - rise_q[i-1], need));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_rs = 1'b0;
		req_data = '0;
		void'($urandom(84711));
		cfg = 7'($urandom);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		rst_cyc = cyc;
		test_init_words();
		test_host_writes();
		test_back_pressure();
		test_pulse_timing();
		test_slot_spacing();
		$display("summary: %0d errors, %0d panel words", errors, obs_q.size());
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	initial begin
		repeat (watchdog_cyc) @(posedge clk);
		$display("timeout: run still going after %0d cycles", watchdog_cyc);
		$display("summary: %0d errors, %0d panel words", errors + 1, obs_q.size());
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== lcd_top.sv ====
`timescale 1ns/1ps
`include "lcd_consts.svh"

module lcd_top import lcd_cfg_pkg::*, lcd_bus_pkg::*; (
	input logic clk,
	input logic rst_n,
	input lcd_cfg_t cfg,
	input logic req_valid,
	output logic req_ready,
	input logic req_rs,
	input logic [7:0] req_data,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data,
	output logic init_done
);

	logic q_valid;
	logic q_ready;
	lcd_word_u q_word;
	logic [1:0] step_idx;
	lcd_word_u init_word;
	logic [`LCD_SLOT_W-1:0] init_slot;
	logic start;
	lcd_word_u word;
	logic [`LCD_SLOT_W-1:0] slot_us;
	logic idle;
	logic done;

	lcd_req_queue i_queue (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_rs(req_rs),
		.req_data(req_data),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_word(q_word)
	);

	lcd_init_seq i_init_seq (
		.step_idx(step_idx),
		.cfg(cfg),
		.init_word(init_word),
		.init_slot(init_slot)
	);

	lcd_bus_timer i_timer (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.word(word),
		.slot_us(slot_us),
		.idle(idle),
		.done(done),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_data(lcd_data)
	);

	lcd_ctrl i_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.step_idx(step_idx),
		.init_word(init_word),
		.init_slot(init_slot),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.q_word(q_word),
		.start(start),
		.word(word),
		.slot_us(slot_us),
		.idle(idle),
		.done(done),
		.init_done(init_done)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LCD controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lcd_tb -f sources.f -o lcd_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/lcd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" sim.log; then
	exit 1
fi
exit 0

// ==== sources.f ====
+incdir+.
lcd_cfg_pkg.sv
lcd_bus_pkg.sv
lcd_req_queue.sv
lcd_init_seq.sv
lcd_bus_timer.sv
lcd_ctrl.sv
lcd_top.sv
lcd_tb.sv
